// File: run_sim.sh
#!/bin/sh
# Build with Verilator, run, and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_rv_core -f rv_core.f -o tb_rv_core \
	&& ./obj_dir/tb_rv_core | tee /dev/stderr | grep -qx "test passed" \
	&& echo "simulation PASSED" \
	|| { echo "simulation FAILED"; exit 1; }

// File: rv_core.f
+incdir+src
src/rv_core_pkg.sv
src/control_unit.sv
src/imm_gen.sv
src/alu.sv
src/reg_file.sv
src/pc_unit.sv
src/load_store_unit.sv
src/rv_core.sv
tb/tb_rv_core.sv

// File: src/alu.sv
`timescale 1ns/1ns
`include "rv_core_defines.svh"

module alu import rv_core_pkg::*; (
	input  ctrl_t            ctrl,
	input  logic [`XLEN-1:0] rd1,
	input  logic [`XLEN-1:0] rd2,
	input  logic [`XLEN-1:0] pc,
	input  logic [`XLEN-1:0] imm,
	input  logic [2:0]       funct3,
	output logic [`XLEN-1:0] alu_result,
	output logic             branch_taken
);

	logic [`XLEN-1:0] op_a;
	logic [`XLEN-1:0] op_b;
	logic [`XLEN-1:0] result;
	logic [`XLEN:0]   diff;
	logic             equal;
	logic             less;
	logic             less_u;

	always_comb begin
		case (ctrl.alu_src_a)
			SRC_A_RD1: op_a = rd1;
			SRC_A_PC:  op_a = pc;
			default:   op_a = '0;
		endcase
		case (ctrl.alu_src_b)
			SRC_B_RD2:   op_b = rd2;
			SRC_B_IMM:   op_b = imm;
			SRC_B_SHAMT: op_b = {{(`XLEN-5){1'b0}}, imm[4:0]};
			default:     op_b = '0;
		endcase
	end

	// One subtractor serves SUB, SLT(U) and the branch compare
	assign diff = {1'b0, op_a} - {1'b0, op_b};
	assign equal = (diff[`XLEN-1:0] == '0);
	assign less_u = diff[`XLEN];
	assign less = (op_a[`XLEN-1] != op_b[`XLEN-1]) ? op_a[`XLEN-1] : diff[`XLEN-1];

	always_comb begin
		case (ctrl.alu_op)
			ALU_ADD:    result = op_a + op_b;
			ALU_SUB:    result = diff[`XLEN-1:0];
			ALU_SLL:    result = op_a << op_b[4:0];
			ALU_SLT:    result = {{(`XLEN-1){1'b0}}, less};
			ALU_SLTU:   result = {{(`XLEN-1){1'b0}}, less_u};
			ALU_XOR:    result = op_a ^ op_b;
			ALU_SRL:    result = op_a >> op_b[4:0];
			ALU_SRA:    result = $signed(op_a) >>> op_b[4:0];
			ALU_OR:     result = op_a | op_b;
			ALU_AND:    result = op_a & op_b;
			ALU_PASS_B: result = op_b;
			default:    result = '0;
		endcase
	end

	always_comb begin
		case (funct3)
			3'b000:  branch_taken = equal;
			3'b001:  branch_taken = !equal;
			3'b100:  branch_taken = less;
			3'b101:  branch_taken = !less;
			3'b110:  branch_taken = less_u;
			3'b111:  branch_taken = !less_u;
			default: branch_taken = 1'b0;
		endcase
		branch_taken = branch_taken && ctrl.branch;
	end

	// Branches report the target, the compare goes out on branch_taken
	assign alu_result = ctrl.branch ? pc + imm : result;

endmodule

// File: src/control_unit.sv
`timescale 1ns/1ns

module control_unit import rv_core_pkg::*; (
	input  inst_fields_t fields,
	input  logic         mem_done,
	output ctrl_t        ctrl,
	output logic         pc_stall
);

	// ALU operation from funct3, alt is funct7 bit 5 where it applies
	function automatic alu_op_e funct_to_op(input logic [2:0] funct3, input logic alt,
			input logic allow_sub);
		case (funct3)
			3'b000: funct_to_op = (alt && allow_sub) ? ALU_SUB : ALU_ADD;
			3'b001: funct_to_op = ALU_SLL;
			3'b010: funct_to_op = ALU_SLT;
			3'b011: funct_to_op = ALU_SLTU;
			3'b100: funct_to_op = ALU_XOR;
			3'b101: funct_to_op = alt ? ALU_SRA : ALU_SRL;
			3'b110: funct_to_op = ALU_OR;
			default: funct_to_op = ALU_AND;
		endcase
	endfunction

	always_comb begin
		ctrl = '0;
		ctrl.alu_op = ALU_ADD;
		ctrl.alu_src_a = SRC_A_NONE;
		ctrl.alu_src_b = SRC_B_NONE;
		ctrl.rf_wd_sel = WD_NONE;

		case (fields.opcode)
			OP_LUI: begin
				// Immediate passes straight through
				ctrl.alu_op = ALU_PASS_B;
				ctrl.alu_src_b = SRC_B_IMM;
				ctrl.register_file_write = 1'b1;
				ctrl.rf_wd_sel = WD_ALU;
			end
			OP_AUIPC: begin
				ctrl.alu_src_a = SRC_A_PC;
				ctrl.alu_src_b = SRC_B_IMM;
				ctrl.register_file_write = 1'b1;
				ctrl.rf_wd_sel = WD_ALU;
			end
			OP_JAL, OP_JALR: begin
				// Target is PC + imm or R[rs1] + imm, link is PC+4
				ctrl.jump = 1'b1;
				ctrl.alu_src_a = (fields.opcode == OP_JAL) ? SRC_A_PC : SRC_A_RD1;
				ctrl.alu_src_b = SRC_B_IMM;
				ctrl.register_file_write = 1'b1;
				ctrl.rf_wd_sel = WD_JUMP;
			end
			OP_BRANCH: begin
				// Compare R[rs1] and R[rs2], alu forms the target
				ctrl.branch = 1'b1;
				ctrl.alu_op = ALU_SUB;
				ctrl.alu_src_a = SRC_A_RD1;
				ctrl.alu_src_b = SRC_B_RD2;
			end
			OP_LOAD, OP_STORE: begin
				// Address is R[rs1] + imm
				ctrl.alu_src_a = SRC_A_RD1;
				ctrl.alu_src_b = SRC_B_IMM;
				ctrl.memory_read = (fields.opcode == OP_LOAD);
				ctrl.memory_write = (fields.opcode == OP_STORE);
				ctrl.register_file_write = (fields.opcode == OP_LOAD);
				ctrl.rf_wd_sel = (fields.opcode == OP_LOAD) ? WD_LOAD : WD_NONE;
			end
			OP_ITYPE: begin
				ctrl.alu_op = funct_to_op(fields.funct3, fields.funct7[5], 1'b0);
				ctrl.alu_src_a = SRC_A_RD1;
				// Shift amount sits in the low immediate bits
				if (fields.funct3 == 3'b001 || fields.funct3 == 3'b101) begin
					ctrl.alu_src_b = SRC_B_SHAMT;
				end else begin
					ctrl.alu_src_b = SRC_B_IMM;
				end
				ctrl.register_file_write = 1'b1;
				ctrl.rf_wd_sel = WD_ALU;
			end
			OP_RTYPE: begin
				ctrl.alu_op = funct_to_op(fields.funct3, fields.funct7[5], 1'b1);
				ctrl.alu_src_a = SRC_A_RD1;
				ctrl.alu_src_b = SRC_B_RD2;
				ctrl.register_file_write = 1'b1;
				ctrl.rf_wd_sel = WD_ALU;
			end
			// FENCE and SYSTEM act as no-ops
			default: begin
			end
		endcase

		// Hold the instruction until the bus access is done
		pc_stall = (ctrl.memory_read || ctrl.memory_write) && !mem_done;
		if (pc_stall) begin
			ctrl.register_file_write = 1'b0;
		end
	end

endmodule

// File: src/imm_gen.sv
`timescale 1ns/1ns
`include "rv_core_defines.svh"

module imm_gen import rv_core_pkg::*; (
	input  logic [`XLEN-1:0] instr,
	output inst_fields_t     fields,
	output logic [`XLEN-1:0] imm
);

	assign fields = inst_fields_t'(instr);

	always_comb begin
		case (fields.opcode)
			// I format
			OP_JALR, OP_LOAD, OP_ITYPE:
				imm = {{20{instr[31]}}, instr[31:20]};
			OP_STORE:
				imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
			OP_BRANCH:
				imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
			// Upper immediate, low 12 bits zero
			OP_LUI, OP_AUIPC:
				imm = {instr[31:12], 12'b0};
			OP_JAL:
				imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
			default:
				imm = '0;
		endcase
	end

endmodule

// File: src/load_store_unit.sv
`timescale 1ns/1ns
`include "rv_core_defines.svh"

module load_store_unit import rv_core_pkg::*; (
	input  logic             clk,
	input  logic             rst_n,
	input  ctrl_t            ctrl,
	input  logic [`XLEN-1:0] addr,
	input  logic [`XLEN-1:0] store_data,
	output wb_m2s_t          wb_out,
	input  wb_s2m_t          wb_in,
	output logic             mem_done,
	output logic [`XLEN-1:0] load_data
);

	lsu_state_e state;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= LSU_IDLE;
			wb_out.cyc <= 1'b0;
			wb_out.stb <= 1'b0;
			wb_out.we <= 1'b0;
		end else begin
			case (state)
				LSU_IDLE: begin
					// Start a word cycle, held until ack
					if (ctrl.memory_read || ctrl.memory_write) begin
						state <= LSU_BUS;
						wb_out.cyc <= 1'b1;
						wb_out.stb <= 1'b1;
						wb_out.we <= ctrl.memory_write;
						wb_out.adr <= addr;
						wb_out.dat <= store_data;
						wb_out.sel <= 4'hF;
					end
				end
				LSU_BUS: begin
					if (wb_in.ack) begin
						state <= LSU_DONE;
						wb_out.cyc <= 1'b0;
						wb_out.stb <= 1'b0;
						wb_out.we <= 1'b0;
						load_data <= wb_in.dat;
					end
				end
				// Instruction retires here
				default: state <= LSU_IDLE;
			endcase
		end
	end

	assign mem_done = (state == LSU_DONE);

endmodule

// File: src/pc_unit.sv
`timescale 1ns/1ns
`include "rv_core_defines.svh"

module pc_unit import rv_core_pkg::*; (
	input  logic             clk,
	input  logic             rst_n,
	input  ctrl_t            ctrl,
	input  logic             pc_stall,
	input  logic             branch_taken,
	input  logic [`XLEN-1:0] alu_result,
	output logic [`XLEN-1:0] pc,
	output logic [`XLEN-1:0] pc_plus4
);

	logic [`XLEN-1:0] pc_next;

	assign pc_plus4 = pc + `XLEN'd4;

	always_comb begin
		if (pc_stall) begin
			pc_next = pc;
		end else if (ctrl.jump) begin
			// JALR target has bit 0 cleared
			pc_next = {alu_result[`XLEN-1:1], 1'b0};
		end else if (branch_taken) begin
			pc_next = alu_result;
		end else begin
			pc_next = pc_plus4;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc <= `RESET_PC;
		end else begin
			pc <= pc_next;
		end
	end

endmodule

// File: src/reg_file.sv
`timescale 1ns/1ns
`include "rv_core_defines.svh"

module reg_file (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic [$clog2(`REG_COUNT)-1:0] rs1,
	input  logic [$clog2(`REG_COUNT)-1:0] rs2,
	input  logic [$clog2(`REG_COUNT)-1:0] rd,
	input  logic                          we,
	input  logic [`XLEN-1:0]              wd,
	output logic [`XLEN-1:0]              rd1,
	output logic [`XLEN-1:0]              rd2
);

	logic [`XLEN-1:0] regs [`REG_COUNT];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (we && rd != '0) begin
			regs[rd] <= wd;
		end
	end

	// x0 always reads zero
	assign rd1 = (rs1 == '0) ? '0 : regs[rs1];
	assign rd2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// File: src/rv_core.sv
`timescale 1ns/1ns
`include "rv_core_defines.svh"

module rv_core import rv_core_pkg::*; (
	input  logic             clk,
	input  logic             rst_n,
	output logic [`XLEN-1:0] instr_addr,
	input  logic [`XLEN-1:0] instr_data,
	output wb_m2s_t          wb_out,
	input  wb_s2m_t          wb_in
);

	inst_fields_t     fields;
	ctrl_t            ctrl;
	logic [`XLEN-1:0] imm;
	logic [`XLEN-1:0] rd1;
	logic [`XLEN-1:0] rd2;
	logic [`XLEN-1:0] wd;
	logic [`XLEN-1:0] alu_result;
	logic [`XLEN-1:0] load_data;
	logic [`XLEN-1:0] pc;
	logic [`XLEN-1:0] pc_plus4;
	logic             branch_taken;
	logic             pc_stall;
	logic             mem_done;

	assign instr_addr = pc;

	imm_gen u_imm_gen (.instr(instr_data), .fields(fields), .imm(imm));

	control_unit u_control_unit (
		.fields(fields), .mem_done(mem_done), .ctrl(ctrl), .pc_stall(pc_stall)
	);

	alu u_alu (
		.ctrl(ctrl), .rd1(rd1), .rd2(rd2), .pc(pc), .imm(imm), .funct3(fields.funct3),
		.alu_result(alu_result), .branch_taken(branch_taken)
	);

	// Write-back source
	always_comb begin
		case (ctrl.rf_wd_sel)
			WD_ALU:  wd = alu_result;
			WD_LOAD: wd = load_data;
			WD_JUMP: wd = pc_plus4;
			default: wd = '0;
		endcase
	end

	reg_file u_reg_file (
		.clk(clk), .rst_n(rst_n), .rs1(fields.rs1), .rs2(fields.rs2), .rd(fields.rd),
		.we(ctrl.register_file_write), .wd(wd), .rd1(rd1), .rd2(rd2)
	);

	pc_unit u_pc_unit (
		.clk(clk), .rst_n(rst_n), .ctrl(ctrl), .pc_stall(pc_stall),
		.branch_taken(branch_taken), .alu_result(alu_result), .pc(pc), .pc_plus4(pc_plus4)
	);

	load_store_unit u_load_store_unit (
		.clk(clk), .rst_n(rst_n), .ctrl(ctrl), .addr(alu_result), .store_data(rd2),
		.wb_out(wb_out), .wb_in(wb_in), .mem_done(mem_done), .load_data(load_data)
	);

endmodule

// File: src/rv_core_defines.svh
`ifndef RV_CORE_DEFINES_SVH
`define RV_CORE_DEFINES_SVH

// Data and address width
`define XLEN 32

// Architectural registers x0 to x31
`define REG_COUNT 32

// First fetch address after reset
`define RESET_PC 32'h0000_0000

`endif

// File: src/rv_core_pkg.sv
`include "rv_core_defines.svh"

package rv_core_pkg;

	// RV32I major opcodes
	typedef enum logic [6:0] {
		OP_LUI    = 7'b0110111,
		OP_AUIPC  = 7'b0010111,
		OP_JAL    = 7'b1101111,
		OP_JALR   = 7'b1100111,
		OP_BRANCH = 7'b1100011,
		OP_LOAD   = 7'b0000011,
		OP_STORE  = 7'b0100011,
		OP_ITYPE  = 7'b0010011,
		OP_RTYPE  = 7'b0110011,
		OP_FENCE  = 7'b0001111,
		OP_SYSTEM = 7'b1110011
	} opcode_e;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
		ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
	} alu_op_e;

	typedef enum logic [1:0] {SRC_A_NONE, SRC_A_RD1, SRC_A_PC} alu_src_a_e;
	typedef enum logic [1:0] {SRC_B_NONE, SRC_B_RD2, SRC_B_IMM, SRC_B_SHAMT} alu_src_b_e;

	// Register file write data source, WD_JUMP is PC+4
	typedef enum logic [1:0] {WD_NONE, WD_ALU, WD_LOAD, WD_JUMP} rf_wd_sel_e;

	typedef enum logic [1:0] {LSU_IDLE, LSU_BUS, LSU_DONE} lsu_state_e;

	// Same bit layout as the instruction word
	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		opcode_e    opcode;
	} inst_fields_t;

	typedef struct packed {
		logic       jump;
		logic       branch;
		alu_op_e    alu_op;
		alu_src_a_e alu_src_a;
		alu_src_b_e alu_src_b;
		logic       register_file_write;
		rf_wd_sel_e rf_wd_sel;
		logic       memory_read;
		logic       memory_write;
	} ctrl_t;

	// Wishbone classic master to slave
	typedef struct packed {
		logic             cyc;
		logic             stb;
		logic             we;
		logic [`XLEN-1:0] adr;
		logic [`XLEN-1:0] dat;
		logic [3:0]       sel;
	} wb_m2s_t;

	typedef struct packed {
		logic             ack;
		logic [`XLEN-1:0] dat;
	} wb_s2m_t;

endpackage

// File: tb/tb_rv_core.sv
`timescale 1ns/1ns
`include "rv_core_defines.svh"

module tb_rv_core import rv_core_pkg::*; ();

	localparam int N_RAND = 48;
	localparam int PROG_LEN = N_RAND + 32 + 1;
	localparam int TIMEOUT = PROG_LEN * 8;
	localparam logic [31:0] HALT_INSN = 32'h0000_006F;
	localparam logic [31:0] HALT_PC = (PROG_LEN - 1) * 4;
	localparam logic [31:0] STORE_BASE = 32'h0000_0200;

	logic clk = 1'b0;
	logic rst_n = 1'b0;
	logic [`XLEN-1:0] instr_addr;
	logic [`XLEN-1:0] instr_data;
	wb_m2s_t wb_out;
	wb_s2m_t wb_in = '0;

	logic [31:0] rom [PROG_LEN];
	logic [31:0] dmem [256];
	logic [31:0] model_mem [256];
	logic [15:0] lfsr = 16'd52408;

	// Model predictions
	logic [31:0] exp_pc [$];
	logic [31:0] exp_adr [$];
	logic [31:0] exp_dat [$];
	logic exp_we [$];

	string names [5] = '{"store data", "load address", "pc trace", "bus protocol", "x0 zero"};
	int checks [5] = '{default: 0};
	int errors [5] = '{default: 0};
	int trace_idx = 0;
	int bus_count = 0;
	int model_bus_count = 0;
	int wait_left = 0;
	int cycles = 0;
	logic busy = 1'b0;
	logic halted = 1'b0;
	logic run_done = 1'b0;
	logic [31:0] last_pc = '1;
	wb_m2s_t held;

	rv_core DUT (
		.clk(clk), .rst_n(rst_n), .instr_addr(instr_addr), .instr_data(instr_data),
		.wb_out(wb_out), .wb_in(wb_in)
	);

	always #4 clk = ~clk;

	// Combinational instruction ROM
	assign instr_data = (instr_addr < PROG_LEN * 4) ? rom[instr_addr[8:2]] : HALT_INSN;

	// Galois LFSR, one step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
		end
		return v;
	endfunction

	function automatic logic [4:0] rand_reg();
		logic [31:0] v;
		v = rand_bits(5);
		return v[4:0];
	endfunction

	task automatic check(input int test, input string what, input logic [31:0] got,
			input logic [31:0] exp);
		checks[test]++;
		if (got !== exp) begin
			errors[test]++;
			$display("Fail at %0t ns: %s got %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic build_program();
		logic [31:0] r;
		logic [4:0] rd;
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic [2:0] kind;
		logic [2:0] f3;
		logic [6:0] f7;
		logic [11:0] imm;
		logic [20:0] off;
		int skip;
		for (int i = 0; i < N_RAND; i++) begin
			rd = rand_reg();
			rs1 = rand_reg();
			rs2 = rand_reg();
			// Regular writes aimed at x0
			if (i % 12 == 5) begin
				rd = 5'd0;
			end
			r = rand_bits(3);
			kind = r[2:0];
			r = rand_bits(3);
			f3 = r[2:0];
			r = rand_bits(12);
			imm = r[11:0];
			case (kind)
				3'd0, 3'd1: begin
					if (f3 == 3'b001) begin
						imm[11:5] = 7'b0;
					end else if (f3 == 3'b101) begin
						imm[11:5] = {1'b0, imm[10], 5'b0};
					end
					rom[i] = {imm, rs1, f3, rd, OP_ITYPE};
				end
				3'd2, 3'd3: begin
					f7 = ((f3 == 3'b000 || f3 == 3'b101) && imm[0]) ? 7'b0100000 : 7'b0;
					rom[i] = {f7, rs2, rs1, f3, rd, OP_RTYPE};
				end
				3'd4, 3'd5: begin
					r = rand_bits(20);
					rom[i] = {r[19:0], rd, (kind == 3'd4) ? OP_LUI : OP_AUIPC};
				end
				3'd6: begin
					// Word from 0x100 to 0x1FC, base x0
					r = rand_bits(6);
					rom[i] = {4'b0001, r[5:0], 2'b00, 5'd0, 3'b010, rd, OP_LOAD};
				end
				default: begin
					// Forward only, never past the first store
					r = rand_bits(2);
					skip = int'(r) + 1;
					if (i + skip > N_RAND) begin
						skip = N_RAND - i;
					end
					off = 21'(skip) << 2;
					if (imm[0]) begin
						rom[i] = {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
					end else begin
						if (f3[2:1] == 2'b01) begin
							f3 = f3 ^ 3'b100;
						end
						rom[i] = {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
					end
				end
			endcase
		end
		// Dump x0 to x31 to STORE_BASE + 4*k
		for (int k = 0; k < 32; k++) begin
			rd = 5'(k);
			imm = {3'b001, 2'b00, rd, 2'b00};
			rom[N_RAND + k] = {imm[11:5], rd, 5'd0, 3'b010, imm[4:0], OP_STORE};
		end
		rom[PROG_LEN - 1] = HALT_INSN;
	endtask

	function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
			input logic [31:0] a, input logic [31:0] b);
		logic [31:0] v;
		case (f3)
			3'd0: v = alt ? a - b : a + b;
			3'd1: v = a << b[4:0];
			3'd2: v = {31'b0, $signed(a) < $signed(b)};
			3'd3: v = {31'b0, a < b};
			3'd4: v = a ^ b;
			3'd5: begin
				if (alt) begin
					v = $signed(a) >>> b[4:0];
				end else begin
					v = a >> b[4:0];
				end
			end
			3'd6: v = a | b;
			default: v = a & b;
		endcase
		return v;
	endfunction

	function automatic logic take_branch(input logic [2:0] f3, input logic [31:0] a,
			input logic [31:0] b);
		case (f3)
			3'd0: return a == b;
			3'd1: return a != b;
			3'd4: return $signed(a) < $signed(b);
			3'd5: return $signed(a) >= $signed(b);
			3'd6: return a < b;
			3'd7: return a >= b;
			default: return 1'b0;
		endcase
	endfunction

	// Instruction-set model, fills the PC trace and the bus queues
	task automatic run_model();
		logic [31:0] xr [32];
		logic [31:0] pc;
		logic [31:0] ins;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] nxt;
		logic [31:0] wval;
		logic [31:0] addr;
		logic [31:0] i_imm;
		logic [31:0] s_imm;
		logic [31:0] b_imm;
		logic [31:0] u_imm;
		logic [31:0] j_imm;
		logic wen;
		for (int k = 0; k < 32; k++) begin
			xr[k] = '0;
		end
		pc = `RESET_PC;
		for (int n = 0; n <= PROG_LEN; n++) begin
			exp_pc.push_back(pc);
			ins = rom[pc[8:2]];
			if (ins == HALT_INSN) begin
				break;
			end
			i_imm = {{20{ins[31]}}, ins[31:20]};
			s_imm = {{20{ins[31]}}, ins[31:25], ins[11:7]};
			b_imm = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
			u_imm = {ins[31:12], 12'b0};
			j_imm = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
			a = xr[ins[19:15]];
			b = xr[ins[24:20]];
			nxt = pc + 4;
			wen = 1'b1;
			wval = '0;
			case (ins[6:0])
				OP_LUI: wval = u_imm;
				OP_AUIPC: wval = pc + u_imm;
				OP_JAL: begin
					wval = pc + 4;
					nxt = pc + j_imm;
				end
				OP_BRANCH: begin
					wen = 1'b0;
					if (take_branch(ins[14:12], a, b)) begin
						nxt = pc + b_imm;
					end
				end
				OP_LOAD: begin
					addr = a + i_imm;
					exp_we.push_back(1'b0);
					exp_adr.push_back(addr);
					exp_dat.push_back('0);
					wval = model_mem[addr[9:2]];
				end
				OP_STORE: begin
					wen = 1'b0;
					addr = a + s_imm;
					exp_we.push_back(1'b1);
					exp_adr.push_back(addr);
					exp_dat.push_back(b);
					model_mem[addr[9:2]] = b;
				end
				OP_ITYPE: wval = alu_ref(ins[14:12], ins[14:12] == 3'b101 && ins[30], a, i_imm);
				OP_RTYPE: wval = alu_ref(ins[14:12], ins[30], a, b);
				default: wen = 1'b0;
			endcase
			if (wen && ins[11:7] != 5'd0) begin
				xr[ins[11:7]] = wval;
			end
			pc = nxt;
		end
	endtask

	// PC trace, consecutive repeats collapsed
	always @(negedge clk) begin
		if (!halted && instr_addr !== last_pc && !$isunknown(instr_addr)) begin
			last_pc = instr_addr;
			if (trace_idx < exp_pc.size()) begin
				check(2, "pc trace", instr_addr, exp_pc[trace_idx]);
			end else begin
				errors[2]++;
				$display("At %0t ns the pc moved past the end of the model trace", $time);
			end
			trace_idx++;
			if (instr_addr == HALT_PC) begin
				halted = 1'b1;
			end
		end
	end

	// Wishbone slave with 0 to 3 random wait cycles
	always @(negedge clk) begin
		logic [31:0] r;
		int tst;
		if (rst_n && wb_out.cyc && wb_out.stb) begin
			if (!busy) begin
				busy = 1'b1;
				held = wb_out;
				bus_count++;
				r = rand_bits(2);
				wait_left = r;
				// Word accesses only
				check(3, "bus sel", {28'b0, wb_out.sel}, 32'h0000_000F);
				if (exp_adr.size() == 0) begin
					errors[3]++;
					$display("At %0t ns a bus cycle started with no matching model access", $time);
				end else begin
					tst = exp_we[0] ? ((exp_adr[0] == STORE_BASE) ? 4 : 0) : 1;
					check(3, "bus we", {31'b0, wb_out.we}, {31'b0, exp_we[0]});
					check(tst, "bus adr", wb_out.adr, exp_adr[0]);
					if (exp_we[0]) begin
						check(tst, "store data", wb_out.dat, exp_dat[0]);
					end
					void'(exp_we.pop_front());
					void'(exp_adr.pop_front());
					void'(exp_dat.pop_front());
				end
				// x0 value checked without the model
				if (wb_out.we && wb_out.adr == STORE_BASE) begin
					check(4, "x0 store", wb_out.dat, 32'h0);
				end
			end else begin
				check(3, "held adr", wb_out.adr, held.adr);
				check(3, "held dat", wb_out.dat, held.dat);
				check(3, "held we/sel", {27'b0, wb_out.we, wb_out.sel}, {27'b0, held.we, held.sel});
			end
			if (wait_left == 0) begin
				wb_in.ack <= 1'b1;
				wb_in.dat <= dmem[wb_out.adr[9:2]];
				if (wb_out.we) begin
					dmem[wb_out.adr[9:2]] = wb_out.dat;
				end
				busy = 1'b0;
			end else begin
				wait_left--;
			end
		end else begin
			if (busy) begin
				errors[3]++;
				busy = 1'b0;
				$display("At %0t ns the master dropped cyc or stb before ack", $time);
			end
			wb_in.ack <= 1'b0;
		end
	end

	initial begin
		while (!run_done && cycles < TIMEOUT) begin
			@(posedge clk);
			cycles++;
		end
		if (!run_done) begin
			$display("Timeout after %0d cycles, the core never reached the halt loop", cycles);
			$display("test failed");
			$finish;
		end
	end

	initial begin
		int total_checks;
		int total_errors;
		for (int i = 0; i < 256; i++) begin
			dmem[i] = rand_bits(32);
			model_mem[i] = dmem[i];
		end
		build_program();
		run_model();
		model_bus_count = exp_adr.size();

		repeat (3) @(posedge clk);
		@(negedge clk);
		rst_n <= 1'b1;

		wait (halted);
		// Core must sit in the halt loop
		repeat (4) begin
			@(negedge clk);
			check(2, "halt loop", instr_addr, HALT_PC);
		end
		run_done = 1'b1;
		check(2, "trace length", trace_idx, exp_pc.size());
		check(3, "bus cycle count", bus_count, model_bus_count);

		total_checks = 0;
		total_errors = 0;
		for (int t = 0; t < 5; t++) begin
			$display("%s: %0d checks, %0d errors", names[t], checks[t], errors[t]);
			total_checks += checks[t];
			total_errors += errors[t];
		end
		$display("total: %0d checks, %0d errors", total_checks, total_errors);
		if (total_errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule
